/* include/int_exec_macros.svh */
`ifndef INT_EXEC_MACROS_SVH
`define INT_EXEC_MACROS_SVH

`define XLEN        32          // data word width
`define NREG        32          // architectural integer registers
`define REGFILE_W   1024        // flat snapshot, NREG words of XLEN
`define INST_W      72          // pre-decoded issue word

// field positions inside the pre-decoded word
`define OPCODE_HI   71
`define OPCODE_LO   65
`define FUNCT3_HI   64
`define FUNCT3_LO   62
`define FUNCT7_HI   61
`define FUNCT7_LO   55
`define RD_HI       54
`define RD_LO       50
`define RS1_HI      49
`define RS1_LO      45
`define RS2_HI      44
`define RS2_LO      40
`define REG_WE_BIT  39          // decoder write hint, stage decides on its own
`define IMM_HI      34          // immediate arrives already sign extended
`define IMM_LO      3

`endif

/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes handled by the integer pipe
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // register-register, incl. M extension
        OPC_OP_IMM = 7'b0010011,    // register-immediate
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 by base instruction
    // mul/mulh/mulhsu/mulhu sit on add/sll/slt/sltu codes
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,           // also sub, mul
        F3_SLL  = 3'b001,           // also mulh
        F3_SLT  = 3'b010,           // also mulhsu
        F3_SLTU = 3'b011,           // also mulhu
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,           // also sra
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef enum logic [6:0] {
        F7_BASE   = 7'b0000000,     // plain base op
        F7_ALT    = 7'b0100000,     // sub, sra, srai
        F7_MULDIV = 7'b0000001      // RV32M group
    } funct7_e;

endpackage

`default_nettype wire

/* src/int_exec_pkg.sv */
`default_nettype none

`include "int_exec_macros.svh"

package int_exec_pkg;

    typedef logic [`XLEN-1:0]         word_t;       // one data word
    typedef logic [$clog2(`NREG)-1:0] reg_idx_t;    // architectural reg index

    // micro-operations seen by the execute units
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_PASS_B,      // lui, operand b straight through
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU
    } exec_op_e;

endpackage

`default_nettype wire

/* src/exec_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface exec_op_if
    import int_exec_pkg::*;
();

    logic     op_valid;     // issue seen and op recognised
    exec_op_e op;           // micro-op
    word_t    opa;          // rs1 or pc
    word_t    opb;          // rs2 or imm
    reg_idx_t rd;           // destination

    modport producer (output op_valid, op, opa, opb, rd);

    modport consumer_mul (input op, opa, opb);

    modport consumer_wb (input op_valid, op, opa, opb, rd);

endinterface

`default_nettype wire

/* src/int_exec_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "int_exec_macros.svh"

module int_exec_decode
    import rv_isa_pkg::*;
    import int_exec_pkg::*;
(
    input  wire                   iq_int_en_i,    // issue strobe
    input  wire word_t            iq_int_addr_i,  // pc of issued inst
    input  wire [`INST_W-1:0]     iq_int_inst_i,  // pre-decoded word
    input  wire [`REGFILE_W-1:0]  reg_rdata_i,    // full register snapshot
    exec_op_if.producer           op_o
);

    opcode_e  opcode;
    funct3_e  funct3;
    funct7_e  funct7;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    word_t    rs1_val;
    word_t    rs2_val;
    exec_op_e dec_op;
    logic     dec_ok;       // opcode/funct combination supported
    logic     use_pc;       // auipc takes pc as operand a
    logic     use_imm;      // everything except OP takes imm as operand b

    assign opcode = opcode_e'(iq_int_inst_i[`OPCODE_HI:`OPCODE_LO]);
    assign funct3 = funct3_e'(iq_int_inst_i[`FUNCT3_HI:`FUNCT3_LO]);
    assign funct7 = funct7_e'(iq_int_inst_i[`FUNCT7_HI:`FUNCT7_LO]);
    assign rs1    = iq_int_inst_i[`RS1_HI:`RS1_LO];
    assign rs2    = iq_int_inst_i[`RS2_HI:`RS2_LO];
    assign imm    = iq_int_inst_i[`IMM_HI:`IMM_LO];

    // x0 comes from the snapshot like any other reg
    assign rs1_val = reg_rdata_i[rs1 * `XLEN +: `XLEN];
    assign rs2_val = reg_rdata_i[rs2 * `XLEN +: `XLEN];

    // funct3 to op for the plain (F7_BASE) encodings
    function automatic exec_op_e base_op(input funct3_e f3);
        case (f3)
            F3_ADD:  return OP_ADD;
            F3_SLL:  return OP_SLL;
            F3_SLT:  return OP_SLT;
            F3_SLTU: return OP_SLTU;
            F3_XOR:  return OP_XOR;
            F3_SRL:  return OP_SRL;
            F3_OR:   return OP_OR;
            F3_AND:  return OP_AND;
            default: return OP_ADD;
        endcase
    endfunction

    always_comb begin
        dec_ok  = 1'b1;
        use_pc  = 1'b0;
        use_imm = 1'b1;
        dec_op  = base_op(funct3);
        case (opcode)
            OPC_OP: begin
                use_imm = 1'b0;
                case (funct7)
                    F7_BASE: begin
                        dec_op = base_op(funct3);       // all eight funct3 legal
                    end
                    F7_ALT: begin
                        if (funct3 == F3_ADD)
                            dec_op = OP_SUB;
                        else if (funct3 == F3_SRL)
                            dec_op = OP_SRA;
                        else
                            dec_ok = 1'b0;
                    end
                    F7_MULDIV: begin
                        case (funct3)
                            F3_ADD:  dec_op = OP_MUL;
                            F3_SLL:  dec_op = OP_MULH;
                            F3_SLT:  dec_op = OP_MULHSU;
                            F3_SLTU: dec_op = OP_MULHU;
                            default: dec_ok = 1'b0;     // div/rem not in this pipe
                        endcase
                    end
                    default: dec_ok = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // only the shifts look at funct7
                if (funct3 == F3_SLL)
                    dec_ok = (funct7 == F7_BASE);
                else if (funct3 == F3_SRL) begin
                    if (funct7 == F7_ALT)
                        dec_op = OP_SRA;
                    else
                        dec_ok = (funct7 == F7_BASE);
                end
            end
            OPC_LUI: dec_op = OP_PASS_B;            // upper imm as is
            OPC_AUIPC: begin
                dec_op = OP_ADD;                    // pc + upper imm
                use_pc = 1'b1;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    assign op_o.op_valid = iq_int_en_i & dec_ok;
    assign op_o.op       = dec_op;
    assign op_o.opa      = use_pc ? iq_int_addr_i : rs1_val;
    assign op_o.opb      = use_imm ? imm : rs2_val;
    assign op_o.rd       = iq_int_inst_i[`RD_HI:`RD_LO];

endmodule

`default_nettype wire

/* src/int_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "int_exec_macros.svh"

module int_mul
    import int_exec_pkg::*;
(
    exec_op_if.consumer_mul op_i,
    output word_t           mul_result_o    // selected product half
);

    logic signed [2*`XLEN-1:0] prod_ss;     // signed x signed
    logic signed [2*`XLEN-1:0] prod_su;     // signed x unsigned
    logic        [2*`XLEN-1:0] prod_uu;     // unsigned x unsigned

    assign prod_ss = $signed(op_i.opa) * $signed(op_i.opb);
    // zero-extended b keeps the multiply signed while b stays positive
    assign prod_su = $signed(op_i.opa) * $signed({1'b0, op_i.opb});
    assign prod_uu = op_i.opa * op_i.opb;

    always_comb begin
        case (op_i.op)
            OP_MUL:    mul_result_o = prod_ss[`XLEN-1:0];          // low half, sign irrelevant
            OP_MULH:   mul_result_o = prod_ss[2*`XLEN-1:`XLEN];
            OP_MULHSU: mul_result_o = prod_su[2*`XLEN-1:`XLEN];
            OP_MULHU:  mul_result_o = prod_uu[2*`XLEN-1:`XLEN];
            default:   mul_result_o = '0;                          // not a multiply
        endcase
    end

endmodule

`default_nettype wire

/* src/int_alu_wb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "int_exec_macros.svh"

module int_alu_wb
    import int_exec_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n_i,
    exec_op_if.consumer_wb     op_i,
    input  wire word_t         mul_result_i,   // from int_mul, same cycle
    output logic               reg_we_o,       // one-cycle write pulse
    output reg_idx_t           reg_waddr_o,
    output word_t              reg_wdata_o
);

    word_t       alu_res;
    word_t       wb_data;
    logic [4:0]  shamt;     // shifts only look at 5 bits
    logic        is_mul;

    assign shamt  = op_i.opb[4:0];
    assign is_mul = op_i.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};

    always_comb begin
        case (op_i.op)
            OP_ADD:    alu_res = op_i.opa + op_i.opb;
            OP_SUB:    alu_res = op_i.opa - op_i.opb;
            OP_XOR:    alu_res = op_i.opa ^ op_i.opb;
            OP_OR:     alu_res = op_i.opa | op_i.opb;
            OP_AND:    alu_res = op_i.opa & op_i.opb;
            OP_SLL:    alu_res = op_i.opa << shamt;
            OP_SRL:    alu_res = op_i.opa >> shamt;
            OP_SRA:    alu_res = $signed(op_i.opa) >>> shamt;   // sign fill
            OP_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_i.opa) < $signed(op_i.opb)};
            OP_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op_i.opa < op_i.opb};
            OP_PASS_B: alu_res = op_i.opb;                       // lui
            default:   alu_res = '0;                             // multiplies come from int_mul
        endcase
    end

    assign wb_data = is_mul ? mul_result_i : alu_res;

    // writeback register, idle cycles drive zeros on addr/data
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
        end else if (op_i.op_valid) begin
            reg_we_o    <= 1'b1;
            reg_waddr_o <= op_i.rd;
            reg_wdata_o <= wb_data;
        end else begin
            reg_we_o    <= 1'b0;    // no issue or unknown encoding
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
        end
    end

    // accepted op fully known before it reaches the write port
    a_op_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        op_i.op_valid |-> !$isunknown({op_i.op, op_i.rd, op_i.opa, op_i.opb}));

    // low product half from int_mul agrees with a plain 32-bit multiply
    a_mul_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        op_i.op_valid && op_i.op == OP_MUL |-> mul_result_i == word_t'(op_i.opa * op_i.opb));

endmodule

`default_nettype wire

/* src/int_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "int_exec_macros.svh"

module int_exec_unit (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       iq_int_en_i,    // issue strobe, no back-pressure
    input  wire [`XLEN-1:0]           iq_int_addr_i,  // pc
    input  wire [`INST_W-1:0]         iq_int_inst_i,  // pre-decoded inst
    input  wire [`REGFILE_W-1:0]      reg_rdata_i,    // all 32 regs, x0 in low word
    output logic                      reg_we_o,
    output logic [$clog2(`NREG)-1:0]  reg_waddr_o,
    output logic [`XLEN-1:0]          reg_wdata_o
);

    exec_op_if op_if ();                    // decoded op, decode -> mul/alu

    logic [`XLEN-1:0] mul_result;          // product half for writeback mux

    int_exec_decode decode_i (
        .iq_int_en_i   (iq_int_en_i),
        .iq_int_addr_i (iq_int_addr_i),
        .iq_int_inst_i (iq_int_inst_i),
        .reg_rdata_i   (reg_rdata_i),
        .op_o          (op_if.producer)
    );

    int_mul mul_i (
        .op_i         (op_if.consumer_mul),
        .mul_result_o (mul_result)
    );

    int_alu_wb alu_wb_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .op_i         (op_if.consumer_wb),
        .mul_result_i (mul_result),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o)
    );

endmodule

`default_nettype wire

/* bench/int_exec_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "int_exec_macros.svh"

module int_exec_unit_tb
    import rv_isa_pkg::*;
    import int_exec_pkg::*;
();

    localparam int TEST_CYCLES = 560;                       // reset, directed groups, random run
    localparam int WATCHDOG_NS = TEST_CYCLES * 10 + 1000;
    // add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic [9:0] R_ALT = 10'b00_1000_0010;        // sub and sra
    // addi slti sltiu xori ori andi slli srli srai
    localparam logic [2:0] I_F3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6,
                                        3'd7, 3'd1, 3'd5, 3'd5};
    localparam logic [8:0] I_ALT = 9'b1_0000_0000;          // srai only

    logic                   clk;
    logic                   rst_n_i;
    logic                   iq_int_en_i;
    word_t                  iq_int_addr_i;
    logic [`INST_W-1:0]     iq_int_inst_i;
    logic [`REGFILE_W-1:0]  reg_rdata_i;
    logic                   reg_we_o;
    reg_idx_t               reg_waddr_o;
    word_t                  reg_wdata_o;

    logic [`REGFILE_W-1:0]  next_regs;      // snapshot staged for the next issue
    logic                   model_valid;    // reference decode says write
    word_t                  model_data;
    logic                   model_issue;
    logic                   exp_we;         // expected outputs, one cycle behind
    reg_idx_t               exp_waddr;
    word_t                  exp_wdata;

    int_exec_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t sra_ref(input word_t a, input logic [4:0] sh);
        word_t r;
        r = a;
        repeat (sh)
            r = {r[31], r[31:1]};           // one step at a time, sign copied in
        return r;
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra_ref(a, b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // extend each side to 64 bits as the funct3 says, then one wide multiply
    function automatic word_t mul_ref(input logic [2:0] f3, input word_t a, input word_t b);
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] p;
        xa = (f3 == 3'd3) ? {32'd0, a} : {{32{a[31]}}, a};                // mulhu: a unsigned
        xb = (f3 == 3'd0 || f3 == 3'd1) ? {{32{b[31]}}, b} : {32'd0, b};  // mulhsu too
        p  = xa * xb;
        return (f3 == 3'd0) ? p[31:0] : p[63:32];
    endfunction

    function automatic void model_write(input logic [`INST_W-1:0] inst, input word_t pc,
                                        input logic [`REGFILE_W-1:0] regs,
                                        output logic valid, output word_t data);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm;
        opc   = inst[`OPCODE_HI:`OPCODE_LO];
        f3    = inst[`FUNCT3_HI:`FUNCT3_LO];
        f7    = inst[`FUNCT7_HI:`FUNCT7_LO];
        imm   = inst[`IMM_HI:`IMM_LO];
        a     = regs[int'(inst[`RS1_HI:`RS1_LO]) * `XLEN +: `XLEN];
        b     = regs[int'(inst[`RS2_HI:`RS2_LO]) * `XLEN +: `XLEN];
        valid = 1'b0;
        data  = '0;
        if (opc == OPC_OP) begin
            valid = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5))
                    || (f7 == F7_MULDIV && f3 < 3'd4);      // div/rem rejected
            data  = (f7 == F7_MULDIV) ? mul_ref(f3, a, b) : alu_ref(f3, f7 == F7_ALT, a, b);
        end else if (opc == OPC_OP_IMM) begin
            if (f3 == 3'd1)
                valid = (f7 == F7_BASE);
            else if (f3 == 3'd5)
                valid = (f7 == F7_BASE || f7 == F7_ALT);
            else
                valid = 1'b1;                               // funct7 don't care
            data = alu_ref(f3, f3 == 3'd5 && f7 == F7_ALT, a, imm);
        end else if (opc == OPC_LUI || opc == OPC_AUIPC) begin
            valid = 1'b1;
            data  = (opc == OPC_LUI) ? imm : pc + imm;
        end
        if (!valid)
            data = '0;
    endfunction

    always_comb begin
        model_write(iq_int_inst_i, iq_int_addr_i, reg_rdata_i, model_valid, model_data);
    end

    assign model_issue = iq_int_en_i && model_valid;

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_we    <= 1'b0;
            exp_waddr <= '0;
            exp_wdata <= '0;
        end else begin
            exp_we    <= model_issue;
            exp_waddr <= model_issue ? iq_int_inst_i[`RD_HI:`RD_LO] : '0;
            exp_wdata <= model_issue ? model_data : '0;
        end
    end

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        $display("ERROR t=%0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "output check failed");
    endtask

    // outputs are registered, so mid-cycle is a quiet place to look
    a_we: assert property (@(negedge clk) disable iff (!rst_n_i) reg_we_o == exp_we)
        else report_mismatch("reg_we_o", 32'(exp_we), 32'(reg_we_o));
    a_waddr: assert property (@(negedge clk) disable iff (!rst_n_i) reg_waddr_o == exp_waddr)
        else report_mismatch("reg_waddr_o", 32'(exp_waddr), 32'(reg_waddr_o));
    a_wdata: assert property (@(negedge clk) disable iff (!rst_n_i) reg_wdata_o == exp_wdata)
        else report_mismatch("reg_wdata_o", exp_wdata, reg_wdata_o);

    task automatic set_reg(input logic [4:0] idx, input word_t val);
        next_regs[int'(idx) * `XLEN +: `XLEN] = val;
    endtask

    task automatic fill_regs();
        for (int i = 0; i < `NREG; i++)
            next_regs[i * `XLEN +: `XLEN] = $urandom;
    endtask

    task automatic issue(input logic en, input logic [6:0] opc, input logic [2:0] f3,
                         input logic [6:0] f7, input logic [4:0] rs1, input logic [4:0] rs2,
                         input word_t imm);
        logic [`INST_W-1:0] w;
        @(negedge clk);
        w = {8'($urandom), $urandom, $urandom};     // spare bits carry noise
        w[`OPCODE_HI:`OPCODE_LO] = opc;
        w[`FUNCT3_HI:`FUNCT3_LO] = f3;
        w[`FUNCT7_HI:`FUNCT7_LO] = f7;
        w[`RD_HI:`RD_LO]         = 5'($urandom);
        w[`RS1_HI:`RS1_LO]       = rs1;
        w[`RS2_HI:`RS2_LO]       = rs2;
        w[`REG_WE_BIT]           = en;
        w[`IMM_HI:`IMM_LO]       = imm;
        iq_int_en_i   = en;
        iq_int_addr_i = $urandom;
        iq_int_inst_i = w;
        reg_rdata_i   = next_regs;
    endtask

    task automatic idle();
        issue(1'b0, 7'($urandom), 3'($urandom), 7'($urandom), 5'($urandom), 5'($urandom),
              $urandom);                            // garbage word, strobe low
    endtask

    initial begin
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [6:0] f7;
        word_t      imm;
        word_t      corner [5];
        int         sel;
        void'($urandom(32'hace0463b));
        rst_n_i       = 1'b0;
        iq_int_en_i   = 1'b0;
        iq_int_addr_i = '0;
        iq_int_inst_i = '0;
        reg_rdata_i   = '0;
        next_regs     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        idle();
        idle();
        for (int k = 0; k < 10; k++) begin          // register-register base ops
            for (int n = 0; n < 6; n++) begin
                fill_regs();
                rs1 = 5'($urandom);
                rs2 = (n < 3) ? rs1 + 5'd1 : 5'($urandom);
                if (n == 0)
                    set_reg(rs2, $urandom | 32'h1f);            // shift by 31
                if (n >= 1)
                    set_reg(rs1, $urandom | 32'h8000_0000);     // negative rs1
                if (n == 2)
                    set_reg(rs2, $urandom | 32'h8000_0000);
                issue(1'b1, OPC_OP, R_F3[k], R_ALT[k] ? F7_ALT : F7_BASE, rs1, rs2, $urandom);
            end
            idle();
        end
        for (int k = 0; k < 11; k++) begin          // immediate ops, then lui and auipc
            for (int n = 0; n < 6; n++) begin
                fill_regs();
                rs1 = 5'($urandom);
                imm = $urandom;
                if (k < 9) begin
                    imm = {{20{imm[11]}}, imm[11:0]};
                    if (n == 0)
                        imm[4:0] = 5'd31;
                    if (n == 1)
                        set_reg(rs1, $urandom | 32'h8000_0000);
                    f7 = 7'($urandom);                          // ignored unless shift
                    if (I_F3[k] == 3'd1 || I_F3[k] == 3'd5)
                        f7 = I_ALT[k] ? F7_ALT : F7_BASE;
                    issue(1'b1, OPC_OP_IMM, I_F3[k], f7, rs1, 5'($urandom), imm);
                end else begin
                    imm[11:0] = 12'd0;
                    issue(1'b1, (k == 9) ? OPC_LUI : OPC_AUIPC, 3'($urandom), 7'($urandom),
                          rs1, 5'($urandom), imm);
                end
            end
            idle();
        end
        corner[0] = 32'h8000_0000;
        corner[1] = 32'hffff_ffff;
        corner[2] = 32'h0;
        corner[3] = 32'h1;
        for (int k = 0; k < 4; k++) begin           // mul, mulh, mulhsu, mulhu
            for (int n = 0; n < 25; n++) begin
                fill_regs();
                corner[4] = $urandom;
                rs1 = 5'($urandom);
                rs2 = rs1 + 5'd1;
                set_reg(rs1, corner[n / 5]);
                set_reg(rs2, corner[n % 5]);
                issue(1'b1, OPC_OP, 3'(k), F7_MULDIV, rs1, rs2, $urandom);
            end
            idle();
        end
        for (int n = 0; n < 300; n++) begin         // back-to-back mix, legal and not
            fill_regs();
            sel = $urandom_range(0, 7);
            case (sel)
                0: issue(1'b1, OPC_OP, 3'($urandom), F7_BASE, 5'($urandom), 5'($urandom),
                         $urandom);
                1: issue(1'b1, OPC_OP, 3'($urandom), F7_ALT, 5'($urandom), 5'($urandom),
                         $urandom);
                2: issue(1'b1, OPC_OP, 3'($urandom), F7_MULDIV, 5'($urandom), 5'($urandom),
                         $urandom);                     // upper funct3 half is div/rem
                3: issue(1'b1, OPC_OP_IMM, 3'($urandom), 7'($urandom & 32'h21), 5'($urandom),
                         5'($urandom), $urandom);
                4: issue(1'b1, ($urandom & 1) ? OPC_LUI : OPC_AUIPC, 3'($urandom),
                         7'($urandom), 5'($urandom), 5'($urandom), $urandom);
                5: issue(1'b1, OPC_OP, 3'($urandom), 7'($urandom), 5'($urandom), 5'($urandom),
                         $urandom);                     // mostly unknown funct7
                6: issue(1'b1, 7'($urandom), 3'($urandom), 7'($urandom), 5'($urandom),
                         5'($urandom), $urandom);       // mostly unknown opcode
                default: idle();
            endcase
        end
        idle();
        idle();
        @(posedge clk);
        #1;
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, stimulus never finished", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* int_exec_unit.f */
+incdir+include
src/rv_isa_pkg.sv
src/int_exec_pkg.sv
src/exec_op_if.sv
src/int_exec_decode.sv
src/int_mul.sv
src/int_alu_wb.sv
src/int_exec_unit.sv
bench/int_exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, verdict from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f int_exec_unit.f \
    --top-module int_exec_unit_tb -o int_exec_unit_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/int_exec_unit_sim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
